// ==== list.f ====
+incdir+src
src/debugPkg.sv
src/serialRx.sv
src/msgParser.sv
src/cmdHandler.sv
src/msgFramer.sv
src/serialTx.sv
src/debugLink.sv
testbench/debugLink_checker.sv
testbench/debugLinkTb.sv

// ==== src/cmdHandler.sv ====
`timescale 1ns/1ps
`include "debugLink_params.svh"

module cmdHandler (
    input  logic              clk,
    input  logic              arstN,
    input  debugPkg::byteT    msgType,
    input  debugPkg::lenT     msgLen,
    input  debugPkg::payloadT msgPayload,
    input  logic              msgValid,
    output debugPkg::ledT     led,
    output debugPkg::byteT    replyType,
    output debugPkg::lenT     replyLen,
    output debugPkg::payloadT replyPayload,
    output logic              replyValid
);
    import debugPkg::*;

    logic isSetLed;
    logic isEcho;
    lenT  echoLen;

    assign isSetLed = msgType == `MSG_TYPE_SET_LED;
    assign isEcho   = msgType == `MSG_TYPE_ECHO;

    // Echo never claims more bytes than were stored
    assign echoLen = (msgLen > lenT'(`MSG_MAX_PAYLOAD_LEN)) ?
        lenT'(`MSG_MAX_PAYLOAD_LEN) : msgLen;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            led        <= '0;
            replyValid <= 1'b0;
        end else begin
            replyValid <= msgValid && (isSetLed || isEcho);
            if (msgValid && isSetLed) begin
                led <= msgPayload[$bits(ledT)-1:0];
            end
        end
    end

    // Reply contents, unknown types leave them untouched
    always_ff @(posedge clk) begin
        if (msgValid && isSetLed) begin
            replyType    <= msgType;
            replyLen     <= lenT'(1);
            replyPayload <= payloadT'(msgPayload[$bits(ledT)-1:0]);
        end else if (msgValid && isEcho) begin
            replyType    <= msgType;
            replyLen     <= echoLen;
            replyPayload <= msgPayload;
        end
    end

endmodule

// ==== src/debugLink.sv ====
`timescale 1ns/1ps

module debugLink (
    input  logic          clk,
    input  logic          arstN,
    input  logic          debugCs,
    input  logic          debugDi,
    output logic          debugDo,
    output debugPkg::ledT led
);
    import debugPkg::*;

    byteT    rxByte;
    logic    rxByteValid;
    byteT    msgType;
    lenT     msgLen;
    payloadT msgPayload;
    logic    msgValid;
    byteT    replyType;
    lenT     replyLen;
    payloadT replyPayload;
    logic    replyValid;
    byteT    txByte;
    logic    txByteValid;
    logic    txByteReq;

    // ========================================================================
    // Inbound path
    // ========================================================================
    serialRx i_serialRx (
        .clk         (clk),
        .arstN       (arstN),
        .debugCs     (debugCs),
        .debugDi     (debugDi),
        .rxByte      (rxByte),
        .rxByteValid (rxByteValid)
    );

    msgParser i_msgParser (
        .clk         (clk),
        .arstN       (arstN),
        .debugCs     (debugCs),
        .rxByte      (rxByte),
        .rxByteValid (rxByteValid),
        .msgType     (msgType),
        .msgLen      (msgLen),
        .msgPayload  (msgPayload),
        .msgValid    (msgValid)
    );

    cmdHandler i_cmdHandler (
        .clk          (clk),
        .arstN        (arstN),
        .msgType      (msgType),
        .msgLen       (msgLen),
        .msgPayload   (msgPayload),
        .msgValid     (msgValid),
        .led          (led),
        .replyType    (replyType),
        .replyLen     (replyLen),
        .replyPayload (replyPayload),
        .replyValid   (replyValid)
    );

    // ========================================================================
    // Outbound path
    // ========================================================================
    msgFramer i_msgFramer (
        .clk          (clk),
        .arstN        (arstN),
        .debugCs      (debugCs),
        .replyType    (replyType),
        .replyLen     (replyLen),
        .replyPayload (replyPayload),
        .replyValid   (replyValid),
        .txByteReq    (txByteReq),
        .txByte       (txByte),
        .txByteValid  (txByteValid)
    );

    serialTx i_serialTx (
        .clk         (clk),
        .arstN       (arstN),
        .debugCs     (debugCs),
        .txByte      (txByte),
        .txByteValid (txByteValid),
        .txByteReq   (txByteReq),
        .debugDo     (debugDo)
    );

endmodule

// ==== src/debugLink_params.svh ====
`ifndef DEBUG_LINK_PARAMS_SVH
`define DEBUG_LINK_PARAMS_SVH

// Serial byte width on debugDi and debugDo
`define BYTE_WIDTH 8

// Payload bytes kept per message
// Longer payloads are counted on the wire but not stored
`define MSG_MAX_PAYLOAD_LEN 5

// Message type codes, zero is the idle byte
`define MSG_TYPE_SET_LED 8'h01
`define MSG_TYPE_ECHO    8'h02

`endif

// ==== src/debugPkg.sv ====
`include "debugLink_params.svh"

package debugPkg;

    // One byte as it travels on the serial link
    typedef logic [`BYTE_WIDTH-1:0] byteT;

    // Payload length field, full wire width
    typedef logic [7:0] lenT;

    // Stored payload, byte 0 in the low bits
    typedef logic [`MSG_MAX_PAYLOAD_LEN*`BYTE_WIDTH-1:0] payloadT;

    typedef logic [3:0] ledT;

    // Inbound message assembly
    typedef enum logic [1:0] {psType, psLen, psPayload, psDone} parseStateT;

    // Outbound reply framing
    typedef enum logic [1:0] {fsIdle, fsType, fsLen, fsPayload} frameStateT;

endpackage

// ==== src/msgFramer.sv ====
`timescale 1ns/1ps
`include "debugLink_params.svh"

module msgFramer (
    input  logic              clk,
    input  logic              arstN,
    input  logic              debugCs,
    input  debugPkg::byteT    replyType,
    input  debugPkg::lenT     replyLen,
    input  debugPkg::payloadT replyPayload,
    input  logic              replyValid,
    input  logic              txByteReq,
    output debugPkg::byteT    txByte,
    output logic              txByteValid
);
    import debugPkg::*;

    localparam int IdxWidth = $clog2(`MSG_MAX_PAYLOAD_LEN);

    frameStateT          frameState;
    logic [IdxWidth-1:0] payIdx;
    byteT                bufType;
    lenT                 bufLen;
    payloadT             bufPayload;
    logic                lastPay;

    assign lastPay = (lenT'(payIdx) + 8'd1) >= bufLen;

    // ========================================================================
    // Byte sequencing, one step per transmitter request
    // ========================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            frameState <= fsIdle;
            payIdx     <= '0;
        end else if (!debugCs) begin
            frameState <= fsIdle;
            payIdx     <= '0;
        end else begin
            case (frameState)
                fsIdle: begin
                    if (replyValid) begin
                        frameState <= fsType;
                    end
                end
                fsType: begin
                    if (txByteReq) begin
                        frameState <= fsLen;
                    end
                end
                fsLen: begin
                    if (txByteReq) begin
                        payIdx     <= '0;
                        frameState <= (bufLen == '0) ? fsIdle : fsPayload;
                    end
                end
                default: begin
                    if (txByteReq) begin
                        payIdx <= payIdx + 1'b1;
                        if (lastPay) begin
                            frameState <= fsIdle;
                        end
                    end
                end
            endcase
        end
    end

    // Reply buffer, a reply that finds the framer busy is lost
    always_ff @(posedge clk) begin
        if (frameState == fsIdle && replyValid) begin
            bufType    <= replyType;
            bufLen     <= replyLen;
            bufPayload <= replyPayload;
        end
    end

    always_comb begin
        txByte      = '0;
        txByteValid = 1'b1;
        case (frameState)
            fsType:    txByte = bufType;
            fsLen:     txByte = bufLen;
            fsPayload: txByte = bufPayload[payIdx*`BYTE_WIDTH +: `BYTE_WIDTH];
            default:   txByteValid = 1'b0;
        endcase
    end

endmodule

// ==== src/msgParser.sv ====
`timescale 1ns/1ps
`include "debugLink_params.svh"

module msgParser (
    input  logic              clk,
    input  logic              arstN,
    input  logic              debugCs,
    input  debugPkg::byteT    rxByte,
    input  logic              rxByteValid,
    output debugPkg::byteT    msgType,
    output debugPkg::lenT     msgLen,
    output debugPkg::payloadT msgPayload,
    output logic              msgValid
);
    import debugPkg::*;

    parseStateT parseState;
    lenT        payCnt;
    logic       lastPayByte;

    assign lastPayByte = (payCnt + 8'd1) == msgLen;

    // ========================================================================
    // Message state machine
    // ========================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            parseState <= psType;
            payCnt     <= '0;
        end else if (!debugCs) begin
            parseState <= psType;
            payCnt     <= '0;
        end else begin
            case (parseState)
                psType: begin
                    // Zero bytes between messages are idle fill
                    if (rxByteValid && rxByte != '0) begin
                        parseState <= psLen;
                    end
                end
                psLen: begin
                    if (rxByteValid) begin
                        payCnt     <= '0;
                        parseState <= (rxByte == '0) ? psDone : psPayload;
                    end
                end
                psPayload: begin
                    if (rxByteValid) begin
                        payCnt <= payCnt + 8'd1;
                        if (lastPayByte) begin
                            parseState <= psDone;
                        end
                    end
                end
                default: begin
                    parseState <= psType;
                end
            endcase
        end
    end

    // Message fields
    always_ff @(posedge clk) begin
        if (rxByteValid) begin
            if (parseState == psType) begin
                msgType <= rxByte;
            end
            if (parseState == psLen) begin
                msgLen <= rxByte;
            end
            // Bytes past the stored limit only advance the count
            if (parseState == psPayload && payCnt < lenT'(`MSG_MAX_PAYLOAD_LEN)) begin
                msgPayload[payCnt*`BYTE_WIDTH +: `BYTE_WIDTH] <= rxByte;
            end
        end
    end

    assign msgValid = (parseState == psDone) && debugCs;

endmodule

// ==== src/serialRx.sv ====
`timescale 1ns/1ps
`include "debugLink_params.svh"

module serialRx (
    input  logic           clk,
    input  logic           arstN,
    input  logic           debugCs,
    input  logic           debugDi,
    output debugPkg::byteT rxByte,
    output logic           rxByteValid
);
    import debugPkg::*;

    localparam int CntWidth = $clog2(`BYTE_WIDTH);

    logic [CntWidth-1:0] bitCnt;
    byteT                shiftReg;
    logic                byteDone;

    // Bit position within the current byte, MSB arrives first
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt   <= '0;
            byteDone <= 1'b0;
        end else if (!debugCs) begin
            bitCnt   <= '0;
            byteDone <= 1'b0;
        end else begin
            bitCnt   <= bitCnt + 1'b1;
            byteDone <= (bitCnt == CntWidth'(`BYTE_WIDTH - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!debugCs) begin
            shiftReg <= '0;
        end else begin
            shiftReg <= {shiftReg[`BYTE_WIDTH-2:0], debugDi};
        end
    end

    // Byte is complete in the cycle after its eighth bit
    assign rxByte      = shiftReg;
    assign rxByteValid = byteDone && debugCs;

endmodule

// ==== src/serialTx.sv ====
`timescale 1ns/1ps
`include "debugLink_params.svh"

module serialTx (
    input  logic           clk,
    input  logic           arstN,
    input  logic           debugCs,
    input  debugPkg::byteT txByte,
    input  logic           txByteValid,
    output logic           txByteReq,
    output logic           debugDo
);
    import debugPkg::*;

    localparam int CntWidth = $clog2(`BYTE_WIDTH);

    logic [CntWidth-1:0] bitCnt;
    byteT                shiftReg;

    // ========================================================================
    // Frame shifter
    // ========================================================================
    // A count of zero means the last bit of the previous frame is on the
    // line and the next byte is loaded at the coming edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt   <= '0;
            shiftReg <= '0;
        end else if (!debugCs) begin
            bitCnt   <= '0;
            shiftReg <= '0;
        end else begin
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == '0) begin
                // Nothing pending, send a zero frame
                shiftReg <= txByteValid ? txByte : '0;
            end else begin
                shiftReg <= shiftReg << 1;
            end
        end
    end

    assign txByteReq = debugCs && (bitCnt == '0);

    // MSB first, forced low when deselected
    assign debugDo = debugCs && shiftReg[`BYTE_WIDTH-1];

endmodule

// ==== testbench/debugLinkTb.sv ====
`timescale 1ns/1ps
`include "debugLink_params.svh"

module debugLinkTb;
    import debugPkg::*;

    localparam int NumMsgs    = 56;
    localparam int CycleLimit = NumMsgs * 120;

    logic clk;
    logic arstN;
    logic debugCs;
    logic debugDi;
    logic debugDo;
    ledT  led;

    // Replies as {type, len, payload}
    logic [55:0] expQ[$];
    logic [55:0] actQ[$];
    event        replyDone;

    int          errCount;
    int          checkCount;
    int          cycleCount;
    ledT         expLed;
    logic [31:0] rngState;

    // Output decoder state
    int          decEdges;
    int          decState;
    int          decIdx;
    byteT        decShift;
    byteT        decType;
    lenT         decLen;
    payloadT     decPay;

    debugLink i_debugLink (
        .clk     (clk),
        .arstN   (arstN),
        .debugCs (debugCs),
        .debugDi (debugDi),
        .debugDo (debugDo),
        .led     (led)
    );

    bind debugLink debugLink_checker i_checker (
        .clk         (clk),
        .arstN       (arstN),
        .debugCs     (debugCs),
        .debugDo     (debugDo),
        .rxByteValid (rxByteValid),
        .replyValid  (replyValid),
        .replyType   (replyType)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Random numbers and reference model
    // ========================================================================
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [71:0] randData();
        logic [95:0] w;
        w[31:0]  = nextRand();
        w[63:32] = nextRand();
        w[95:64] = nextRand();
        return w[71:0];
    endfunction

    // Returns 1 when the message gets a reply
    function automatic bit refReply(input byteT t, input lenT l, input payloadT p,
                                    input ledT ledIn, output ledT ledOut,
                                    output logic [55:0] reply);
        lenT     rLen;
        payloadT rPay;
        int      i;
        ledOut = ledIn;
        reply  = '0;
        if (t == `MSG_TYPE_SET_LED) begin
            ledOut = p[3:0];
            reply  = {t, 8'd1, 32'd0, 4'd0, ledOut};
            return 1'b1;
        end
        if (t == `MSG_TYPE_ECHO) begin
            rLen = (l > `MSG_MAX_PAYLOAD_LEN) ? lenT'(`MSG_MAX_PAYLOAD_LEN) : l;
            rPay = '0;
            for (i = 0; i < rLen; i++) begin
                rPay[i*8 +: 8] = p[i*8 +: 8];
            end
            reply = {t, rLen, rPay};
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // ========================================================================
    // Stimulus tasks
    // ========================================================================
    task automatic sendByte(input byteT b);
        int i;
        for (i = 7; i >= 0; i--) begin
            @(negedge clk);
            debugCs = 1'b1;
            debugDi = b[i];
        end
    endtask

    task automatic checkLed();
        checkCount++;
        assert (led == expLed)
            else begin
                errCount++;
                $display("Error: %0t ns led is %h, expected %h", $time, led, expLed);
            end
    endtask

    task automatic sendMsg(input byteT t, input lenT l, input logic [71:0] data);
        logic [55:0] exp;
        ledT         newLed;
        int          i;
        if (refReply(t, l, data[39:0], expLed, newLed, exp)) begin
            expQ.push_back(exp);
        end
        sendByte(t);
        sendByte(l);
        for (i = 0; i < l; i++) begin
            sendByte(data[i*8 +: 8]);
        end
        repeat (6) sendByte(8'h00);
        // Keep the line idle until the reply has been decoded
        while (expQ.size() != 0) begin
            sendByte(8'h00);
        end
        expLed = newLed;
        checkLed();
    endtask

    // Starts a SetLED and deselects three bits into its payload
    task automatic dropMidMessage(input byteT partial);
        int i;
        sendByte(`MSG_TYPE_SET_LED);
        sendByte(8'd1);
        for (i = 7; i >= 5; i--) begin
            @(negedge clk);
            debugDi = partial[i];
        end
        @(negedge clk);
        debugCs = 1'b0;
        debugDi = 1'b0;
        repeat (16) @(negedge clk);
        checkLed();
    endtask

    // ========================================================================
    // Output decoder
    // ========================================================================
    task automatic takeByte(input byteT b);
        case (decState)
            0: begin
                if (b != '0) begin
                    decType  = b;
                    decState = 1;
                end
            end
            1: begin
                decLen   = b;
                decPay   = '0;
                decIdx   = 0;
                decState = 2;
                if (b == '0) begin
                    actQ.push_back({decType, decLen, decPay});
                    -> replyDone;
                    decState = 0;
                end
            end
            default: begin
                if (decIdx < `MSG_MAX_PAYLOAD_LEN) begin
                    decPay[decIdx*8 +: 8] = b;
                end
                decIdx++;
                if (decIdx == decLen) begin
                    actQ.push_back({decType, decLen, decPay});
                    -> replyDone;
                    decState = 0;
                end
            end
        endcase
    endtask

    // Bit n of frame k is on the line between edges 8k+n+1 and 8k+n+2
    always @(posedge clk) begin
        if (!arstN || !debugCs) begin
            decEdges = 0;
            decState = 0;
            decShift = '0;
        end else begin
            if (decEdges != 0) begin
                decShift = {decShift[6:0], debugDo};
                if ((decEdges - 1) % 8 == 7) begin
                    takeByte(decShift);
                end
            end
            decEdges++;
        end
    end

    // Reply comparison
    initial begin
        logic [55:0] exp;
        logic [55:0] act;
        forever begin
            @(replyDone);
            while (actQ.size() != 0) begin
                act = actQ.pop_front();
                checkCount++;
                assert (expQ.size() != 0)
                    else begin
                        errCount++;
                        $display("A reply came out when none was expected at %0t ns: %h",
                                 $time, act);
                    end
                if (expQ.size() != 0) begin
                    exp = expQ.pop_front();
                    assert (act == exp)
                        else begin
                            errCount++;
                            $display("Error: %0t ns reply %h, expected %h", $time, act, exp);
                        end
                end
            end
        end
    end

    // Run limit
    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("The run did not finish within %0d cycles", CycleLimit);
        $display("Checks: %0d, errors: %0d", checkCount, errCount + 1);
        $display("Result: FAILED");
        $finish;
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        logic [31:0] r;
        logic [71:0] data;
        int          n;
        int          totalErr;
        arstN      = 1'b0;
        debugCs    = 1'b0;
        debugDi    = 1'b0;
        errCount   = 0;
        checkCount = 0;
        expLed     = '0;
        rngState   = 32'h220d_cb6a;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        repeat (2) @(negedge clk);

        for (n = 0; n < 2; n++) begin
            sendMsg(`MSG_TYPE_SET_LED, 8'd1, randData());
        end

        // Every stored length, then lengths past the limit
        for (n = 0; n <= 5; n++) begin
            sendMsg(`MSG_TYPE_ECHO, lenT'(n), randData());
        end
        for (n = 6; n <= 9; n++) begin
            sendMsg(`MSG_TYPE_ECHO, lenT'(n), randData());
        end

        repeat (3) sendByte(8'h00);
        sendMsg(`MSG_TYPE_ECHO, 8'd2, randData());
        sendMsg(8'h5A, 8'd2, randData());

        data = randData();
        dropMidMessage(data[7:0]);
        sendMsg(`MSG_TYPE_SET_LED, 8'd1, randData());

        for (n = 0; n < 40; n++) begin
            r = nextRand();
            if (r[0]) begin
                sendMsg(`MSG_TYPE_SET_LED, 8'd1, randData());
            end else begin
                sendMsg(`MSG_TYPE_ECHO, lenT'(r[15:8] % 6), randData());
            end
        end

        // Late stray replies still reach the comparison
        repeat (10) sendByte(8'h00);

        totalErr = errCount + i_debugLink.i_checker.assertFails;
        $display("Checks: %0d, errors: %0d", checkCount, totalErr);
        if (totalErr == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/debugLink_checker.sv ====
`timescale 1ns/1ps

module debugLink_checker (
    input logic           clk,
    input logic           arstN,
    input logic           debugCs,
    input logic           debugDo,
    input logic           rxByteValid,
    input logic           replyValid,
    input debugPkg::byteT replyType
);

    // Read by the testbench when it totals the errors
    int assertFails = 0;

    // Received bytes are at least eight cycles apart
    assert property (@(posedge clk) disable iff (!arstN) rxByteValid |=> !rxByteValid)
        else begin
            assertFails++;
            $error("rxByteValid was high in two consecutive cycles");
        end

    // Output line is quiet while deselected
    assert property (@(posedge clk) disable iff (!arstN) !debugCs |-> !debugDo)
        else begin
            assertFails++;
            $error("debugDo was high while debugCs was low");
        end

    // Type zero is the idle byte and can never start a reply
    assert property (@(posedge clk) disable iff (!arstN) replyValid |-> replyType != '0)
        else begin
            assertFails++;
            $error("replyValid was high with a zero replyType");
        end

endmodule
